// File: eth_rx_pkg.sv
package eth_rx_pkg;

   // Widths with a meaning of their own
   typedef logic [3:0]  nibble_t;
   typedef logic [7:0]  byte_t;
   typedef logic [10:0] byte_addr_t;
   typedef logic [8:0]  word_addr_t;
   typedef logic [31:0] word_t;
   typedef logic [31:0] crc_t;

   // Receiver FSM
   typedef enum logic [2:0] {
      IDLE,
      PREAMBLE,
      DEST,
      DATA,
      DROP,
      HOLD
   } rx_state_t;

   // One byte write into the frame buffer
   typedef struct packed {
      logic       wr;
      byte_addr_t addr;
      byte_t      data;
   } eth_rx_wr_t;

   // Receive status seen by the consumer
   typedef struct packed {
      logic       data_rcvd;
      logic       crc_ok;
      logic       dv_detected;
      byte_addr_t rcv_size;
   } eth_rx_status_t;

   localparam logic [47:0] ETH_MAC_ADDR  = 48'h0102_0304_0506;
   localparam logic [47:0] ETH_BROADCAST = 48'hFFFF_FFFF_FFFF;
   localparam int          MAC_BYTES     = 6;

   localparam nibble_t PREAMBLE_NIBBLE = 4'h5;
   localparam nibble_t SFD_NIBBLE      = 4'hD;

   // Reflected form of 0x04C11DB7
   localparam crc_t CRC_POLY    = 32'hEDB8_8320;
   localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;

   localparam int BUF_WORDS = 512;

endpackage

// File: eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32
   import eth_rx_pkg::*;
(
   input  logic  RX_CLK,
   input  logic  ETH_PHY_RESETN,
   input  logic  crc_clear,
   input  logic  crc_en,
   input  byte_t crc_data,
   output crc_t  crc
);

   crc_t crc_q;

   // One byte, LSB first
   function automatic crc_t crc_byte(input crc_t c, input byte_t d);
      crc_t r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         if (r[0] ^ d[i]) begin
            r = (r >> 1) ^ CRC_POLY;
         end else begin
            r = r >> 1;
         end
      end
      return r;
   endfunction

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc_q <= '1;
      end else if (crc_clear) begin
         crc_q <= '1;
      end else if (crc_en) begin
         crc_q <= crc_byte(crc_q, crc_data);
      end
   end

   assign crc = ~crc_q;

   // Clear comes at the SFD, bytes only after it
   a_clear_en_excl: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      !(crc_clear && crc_en));

endmodule

// File: eth_rx_frame.sv
`timescale 1ns/1ps

module eth_rx_frame
   import eth_rx_pkg::*;
(
   input  logic           RX_CLK,
   input  logic           ETH_PHY_RESETN,
   input  nibble_t        RX_DATA,
   input  logic           RX_DV,
   input  logic           rcv_ack,
   input  crc_t           crc,
   output eth_rx_wr_t     buf_wr,
   output logic           crc_clear,
   output logic           crc_en,
   output byte_t          crc_data,
   output eth_rx_status_t status
);

   rx_state_t  state;
   logic       half;
   nibble_t    lo_nib;
   byte_addr_t byte_cnt;
   logic [39:0] dest_sr;
   logic       data_rcvd;
   logic       dv_detected;
   byte_addr_t rcv_size;

   byte_t       cur_byte;
   logic [47:0] dest_word;
   logic        addr_hit;
   logic        last_dest;

   // Byte being completed by the nibble on RX_DATA
   assign cur_byte  = {RX_DATA, lo_nib};
   assign dest_word = {dest_sr, cur_byte};
   assign addr_hit  = (dest_word == ETH_MAC_ADDR) || (dest_word == ETH_BROADCAST);
   assign last_dest = (state == DEST) && (byte_cnt == byte_addr_t'(MAC_BYTES - 1));

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state       <= IDLE;
         half        <= 1'b0;
         byte_cnt    <= '0;
         buf_wr      <= '0;
         data_rcvd   <= 1'b0;
         dv_detected <= 1'b0;
         rcv_size    <= '0;
      end else begin
         buf_wr.wr <= 1'b0;
         if (RX_DV) begin
            dv_detected <= 1'b1;
         end
         case (state)
            IDLE: begin
               // Start of DV must be preamble, else skip the whole frame
               if (RX_DV) begin
                  state <= (RX_DATA == PREAMBLE_NIBBLE) ? PREAMBLE : DROP;
               end
            end
            PREAMBLE: begin
               if (!RX_DV) begin
                  state <= IDLE;
               end else if (RX_DATA == SFD_NIBBLE) begin
                  state    <= DEST;
                  half     <= 1'b0;
                  byte_cnt <= '0;
               end else if (RX_DATA != PREAMBLE_NIBBLE) begin
                  state <= DROP;
               end
            end
            DEST, DATA: begin
               if (!RX_DV) begin
                  // Runt frames ending inside the address are discarded
                  if (state == DATA) begin
                     state     <= HOLD;
                     data_rcvd <= 1'b1;
                     rcv_size  <= byte_cnt;
                  end else begin
                     state <= IDLE;
                  end
               end else begin
                  half <= ~half;
                  if (half) begin
                     if (last_dest && !addr_hit) begin
                        state <= DROP;
                     end else begin
                        buf_wr.wr   <= 1'b1;
                        buf_wr.addr <= byte_cnt;
                        buf_wr.data <= cur_byte;
                        byte_cnt    <= byte_cnt + 1'b1;
                        if (last_dest) begin
                           state <= DATA;
                        end
                     end
                  end
               end
            end
            DROP: begin
               if (!RX_DV) begin
                  state <= IDLE;
               end
            end
            HOLD: begin
               if (rcv_ack) begin
                  state     <= IDLE;
                  data_rcvd <= 1'b0;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Nibble pairing and destination capture
   always_ff @(posedge RX_CLK) begin
      if (!half) begin
         lo_nib <= RX_DATA;
      end else if (state == DEST) begin
         dest_sr <= dest_word[39:0];
      end
   end

   assign crc_clear = (state == PREAMBLE) && RX_DV && (RX_DATA == SFD_NIBBLE);
   assign crc_en    = buf_wr.wr;
   assign crc_data  = buf_wr.data;

   // CRC has taken the last byte by the time HOLD is entered
   // Residue is defined on the raw register, so undo the output inversion
   always_comb begin
      status.data_rcvd   = data_rcvd;
      status.crc_ok      = (state == HOLD) && (~crc == CRC_RESIDUE);
      status.dv_detected = dv_detected;
      status.rcv_size    = rcv_size;
   end

   a_no_wr_idle: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      (state == HOLD || state == DROP) |-> !buf_wr.wr);

   // Writes come every second cycle inside a frame
   a_addr_step: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      (buf_wr.wr && $past(buf_wr.wr, 2)) |->
         (buf_wr.addr == byte_addr_t'($past(buf_wr.addr, 2) + 1'b1)));

   a_ack_clear: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      $fell(data_rcvd) |-> $past(rcv_ack));

endmodule

// File: eth_rx_buffer.sv
`timescale 1ns/1ps

module eth_rx_buffer
   import eth_rx_pkg::*;
(
   input  logic       RX_CLK,
   input  eth_rx_wr_t buf_wr,
   input  logic       rd_en,
   input  word_addr_t rd_addr,
   output word_t      rd_data
);

   word_t mem [BUF_WORDS];

   word_addr_t wr_word;
   logic [1:0] wr_lane;

   // Upper bits pick the word, lower two the byte lane
   assign wr_word = buf_wr.addr[10:2];
   assign wr_lane = buf_wr.addr[1:0];

   // Lane 0 is the least significant byte
   always_ff @(posedge RX_CLK) begin
      if (buf_wr.wr) begin
         mem[wr_word][8 * wr_lane +: 8] <= buf_wr.data;
      end
   end

   // Registered read, old data on a same-cycle collision
   always_ff @(posedge RX_CLK) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

// File: eth_rx_core.sv
`timescale 1ns/1ps

module eth_rx_core
   import eth_rx_pkg::*;
(
   input  logic           RX_CLK,
   input  logic           ETH_PHY_RESETN,
   input  nibble_t        RX_DATA,
   input  logic           RX_DV,
   input  logic           rcv_ack,
   input  logic           rd_en,
   input  word_addr_t     rd_addr,
   output word_t          rd_data,
   output eth_rx_status_t status
);

   eth_rx_wr_t buf_wr;
   logic       crc_clear;
   logic       crc_en;
   byte_t      crc_data;
   crc_t       crc;

   // MII receiver and address filter
   eth_rx_frame frame0 (
      .RX_CLK        (RX_CLK),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .RX_DATA       (RX_DATA),
      .RX_DV         (RX_DV),
      .rcv_ack       (rcv_ack),
      .crc           (crc),
      .buf_wr        (buf_wr),
      .crc_clear     (crc_clear),
      .crc_en        (crc_en),
      .crc_data      (crc_data),
      .status        (status)
   );

   // FCS check over destination through FCS
   eth_crc32 crc0 (
      .RX_CLK        (RX_CLK),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .crc_clear     (crc_clear),
      .crc_en        (crc_en),
      .crc_data      (crc_data),
      .crc           (crc)
   );

   // Frame storage, word read port for the consumer
   eth_rx_buffer buf0 (
      .RX_CLK (RX_CLK),
      .buf_wr (buf_wr),
      .rd_en  (rd_en),
      .rd_addr(rd_addr),
      .rd_data(rd_data)
   );

endmodule

// File: tb_eth_rx.sv
`timescale 1ns/1ps

module tb_eth_rx
   import eth_rx_pkg::*;
();

   localparam int LEN_MAIN    = 50;
   localparam int LEN_FOREIGN = 40;
   localparam int LEN_BCAST   = 30;
   localparam int LEN_FIRST   = 20;
   localparam int LEN_BLOCKED = 30;
   localparam int LEN_NEXT    = 25;
   localparam int PAYLOAD_SUM = 2 * LEN_MAIN + LEN_FOREIGN + LEN_BCAST + LEN_FIRST
                                + LEN_BLOCKED + LEN_NEXT;
   // Seven frames, each with preamble, SFD, address and FCS around the payload
   localparam int FRAME_NIBBLES   = 7 * (16 + 2 * 10) + 2 * PAYLOAD_SUM;
   localparam int WATCHDOG_CYCLES = 2 * FRAME_NIBBLES + 1000;

   logic           RX_CLK;
   logic           ETH_PHY_RESETN;
   nibble_t        RX_DATA;
   logic           RX_DV;
   logic           rcv_ack;
   logic           rd_en;
   word_addr_t     rd_addr;
   word_t          rd_data;
   eth_rx_status_t status;

   integer seed;
   integer seed_save;
   byte_t  tx_bytes [2048];
   byte_t  exp_bytes [2048];
   int     tx_len;
   int     exp_size;
   logic   exp_crc_ok;
   word_t  rd_exp;
   word_t  rd_mask;
   logic   seen_dv;
   logic   expect_none;
   logic   expect_hold;
   int     errors;
   int     errors_mark;
   int     passed;
   int     failed;

   eth_rx_core dut0 (
      .RX_CLK        (RX_CLK),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .RX_DATA       (RX_DATA),
      .RX_DV         (RX_DV),
      .rcv_ack       (rcv_ack),
      .rd_en         (rd_en),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .status        (status)
   );

   always #10 RX_CLK = ~RX_CLK;

   task automatic report_mismatch(input string sig, input logic [31:0] expv,
                                  input logic [31:0] actv);
      errors = errors + 1;
      $display("FAIL %0t %s expected %h got %h", $time, sig, expv, actv);
   endtask

   a_reset_status: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      !seen_dv |-> status == '0)
      else report_mismatch("status", 32'h0, 32'(status));
   a_dv_sticky: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      (seen_dv && $past(seen_dv)) |-> status.dv_detected)
      else report_mismatch("status.dv_detected", 32'h1, 32'(status.dv_detected));
   a_crc_ok: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      status.data_rcvd |-> status.crc_ok == exp_crc_ok)
      else report_mismatch("status.crc_ok", 32'(exp_crc_ok), 32'(status.crc_ok));
   a_size: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      status.data_rcvd |-> status.rcv_size == byte_addr_t'(exp_size))
      else report_mismatch("status.rcv_size", 32'(exp_size), 32'(status.rcv_size));
   a_no_rcvd: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      expect_none |-> !status.data_rcvd)
      else report_mismatch("status.data_rcvd", 32'h0, 32'(status.data_rcvd));
   a_hold: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      expect_hold |-> status.data_rcvd)
      else report_mismatch("status.data_rcvd", 32'h1, 32'(status.data_rcvd));
   a_ack: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      $past(rcv_ack && status.data_rcvd) |-> !status.data_rcvd)
      else report_mismatch("status.data_rcvd", 32'h0, 32'(status.data_rcvd));
   // Only lanes that hold frame bytes are compared
   a_read: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      $past(rd_en) |-> (rd_data & $past(rd_mask)) == $past(rd_exp))
      else report_mismatch("rd_data", $past(rd_exp), rd_data & $past(rd_mask));

   // Reflected CRC-32, register preset to ones, result inverted
   function automatic crc_t fcs_of(input int n);
      crc_t r;
      r = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++) begin
         for (int b = 0; b < 8; b++) begin
            r = (r >> 1) ^ (32'hEDB8_8320 & {32{r[0] ^ tx_bytes[i][b]}});
         end
      end
      return ~r;
   endfunction

   task automatic build_frame(input logic [47:0] dest, input int len, input bit corrupt);
      crc_t fcs;
      tx_len = 6 + len + 4;
      for (int i = 0; i < 6; i++) begin
         tx_bytes[i] = dest[47 - 8 * i -: 8];
      end
      for (int i = 0; i < len; i++) begin
         tx_bytes[6 + i] = byte_t'($random(seed));
      end
      fcs = fcs_of(6 + len);
      // FCS goes out least significant byte first
      for (int i = 0; i < 4; i++) begin
         tx_bytes[6 + len + i] = fcs[8 * i +: 8];
      end
      if (corrupt) begin
         tx_bytes[6 + len / 2][3] = ~tx_bytes[6 + len / 2][3];
      end
   endtask

   task automatic commit_expect(input logic crc_good);
      for (int i = 0; i < tx_len; i++) begin
         exp_bytes[i] = tx_bytes[i];
      end
      exp_size   = tx_len;
      exp_crc_ok = crc_good;
   endtask

   task automatic drive_frame();
      for (int i = 0; i < 16; i++) begin
         @(negedge RX_CLK);
         RX_DV   = 1'b1;
         RX_DATA = (i == 15) ? SFD_NIBBLE : PREAMBLE_NIBBLE;
      end
      // Low nibble first
      for (int i = 0; i < tx_len; i++) begin
         @(negedge RX_CLK);
         RX_DATA = tx_bytes[i][3:0];
         @(negedge RX_CLK);
         RX_DATA = tx_bytes[i][7:4];
      end
      @(negedge RX_CLK);
      RX_DV   = 1'b0;
      RX_DATA = 4'h0;
      repeat (4) @(negedge RX_CLK);
   endtask

   task automatic wait_rcvd();
      int n;
      n = 0;
      while (!status.data_rcvd && n < 50) begin
         @(negedge RX_CLK);
         n++;
      end
      if (!status.data_rcvd) begin
         errors = errors + 1;
         $display("data_rcvd did not rise within 50 cycles after the frame at %0t", $time);
      end
   endtask

   task automatic check_buffer();
      for (int w = 0; w < (exp_size + 3) / 4; w++) begin
         @(negedge RX_CLK);
         rd_en   = 1'b1;
         rd_addr = word_addr_t'(w);
         for (int k = 0; k < 4; k++) begin
            if (4 * w + k < exp_size) begin
               rd_exp[8 * k +: 8]  = exp_bytes[4 * w + k];
               rd_mask[8 * k +: 8] = 8'hFF;
            end else begin
               rd_exp[8 * k +: 8]  = 8'h00;
               rd_mask[8 * k +: 8] = 8'h00;
            end
         end
      end
      @(negedge RX_CLK);
      rd_en = 1'b0;
      @(negedge RX_CLK);
   endtask

   task automatic pulse_ack();
      @(negedge RX_CLK);
      rcv_ack = 1'b1;
      @(negedge RX_CLK);
      rcv_ack = 1'b0;
      @(negedge RX_CLK);
   endtask

   task automatic report_test(input string name);
      if (errors == errors_mark) begin
         passed++;
         $display("test %s ok", name);
      end else begin
         failed++;
         $display("test %s failed with %0d errors", name, errors - errors_mark);
      end
      errors_mark = errors;
   endtask

   initial begin
      #(WATCHDOG_CYCLES * 20);
      $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      RX_CLK         = 1'b0;
      ETH_PHY_RESETN = 1'b0;
      RX_DATA        = 4'h0;
      RX_DV          = 1'b0;
      rcv_ack        = 1'b0;
      rd_en          = 1'b0;
      rd_addr        = '0;
      seed           = 32'hd9f4_e197;
      rd_exp         = '0;
      rd_mask        = '0;
      exp_size       = 0;
      exp_crc_ok     = 1'b0;
      seen_dv        = 1'b0;
      expect_none    = 1'b0;
      expect_hold    = 1'b0;
      errors         = 0;
      errors_mark    = 0;
      passed         = 0;
      failed         = 0;
      repeat (10) @(negedge RX_CLK);
      ETH_PHY_RESETN = 1'b1;
      repeat (5) @(negedge RX_CLK);

      // Short burst without preamble, dropped by the receiver
      RX_DV   = 1'b1;
      seen_dv = 1'b1;
      repeat (3) @(negedge RX_CLK);
      RX_DV = 1'b0;
      repeat (4) @(negedge RX_CLK);
      report_test("reset status and dv_detected");

      seed_save = seed;
      build_frame(ETH_MAC_ADDR, LEN_MAIN, 1'b0);
      commit_expect(1'b1);
      drive_frame();
      wait_rcvd();
      check_buffer();
      pulse_ack();
      report_test("unicast frame with good FCS");

      seed = seed_save;
      build_frame(ETH_MAC_ADDR, LEN_MAIN, 1'b1);
      commit_expect(1'b0);
      drive_frame();
      wait_rcvd();
      pulse_ack();
      report_test("frame with flipped payload bit");

      expect_none = 1'b1;
      build_frame(48'h0102_0304_0507, LEN_FOREIGN, 1'b0);
      drive_frame();
      repeat (20) @(negedge RX_CLK);
      expect_none = 1'b0;
      build_frame(ETH_BROADCAST, LEN_BCAST, 1'b0);
      commit_expect(1'b1);
      drive_frame();
      wait_rcvd();
      check_buffer();
      pulse_ack();
      report_test("address filter");

      build_frame(ETH_MAC_ADDR, LEN_FIRST, 1'b0);
      commit_expect(1'b1);
      drive_frame();
      wait_rcvd();
      // Second frame arrives while the first is unacknowledged
      expect_hold = 1'b1;
      build_frame(ETH_MAC_ADDR, LEN_BLOCKED, 1'b0);
      drive_frame();
      repeat (10) @(negedge RX_CLK);
      expect_hold = 1'b0;
      check_buffer();
      pulse_ack();
      build_frame(ETH_MAC_ADDR, LEN_NEXT, 1'b0);
      commit_expect(1'b1);
      drive_frame();
      wait_rcvd();
      check_buffer();
      pulse_ack();
      report_test("frame during hold and acknowledge");

      $display("tests passed %0d failed %0d", passed, failed);
      if (failed == 0 && errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: flist.f
eth_rx_pkg.sv
eth_crc32.sv
eth_rx_frame.sv
eth_rx_buffer.sv
eth_rx_core.sv
tb_eth_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MII receive testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_rx \
   -f flist.f -o sim_eth_rx \
   && ./obj_dir/sim_eth_rx > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "=== PASS ===" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
